/* hdl/frog_geom_pkg.sv */
`default_nettype none

package frog_geom_pkg;

    // Pixel coordinate
    // All position arithmetic wraps modulo 512
    typedef logic [8:0] coord_t;

    // One bit each for red, green and blue
    typedef logic [2:0] color_t;

    // Visible screen
    localparam coord_t scrn_w = 9'd320;
    localparam coord_t scrn_h = 9'd240;

    // River object sprite
    localparam coord_t river_w = 9'd96;
    localparam coord_t river_h = 9'd30;

    // Frog sprite and its largest top-left corner
    localparam coord_t frog_w     = 9'd32;
    localparam coord_t frog_h     = 9'd24;
    localparam coord_t frog_max_x = 9'd287;
    localparam coord_t frog_max_y = 9'd215;

    // Spawn corners of the three river rows
    localparam coord_t river_1_x = 9'd0;
    localparam coord_t river_1_y = 9'd75;
    localparam coord_t river_2_x = 9'd319;
    localparam coord_t river_2_y = 9'd115;
    localparam coord_t river_3_x = 9'd0;
    localparam coord_t river_3_y = 9'd155;

    // Fixed palette, one color per layer
    localparam color_t color_start     = 3'd1;
    localparam color_t color_game_over = 3'd4;
    localparam color_t color_bg        = 3'd2;
    localparam color_t color_river_1   = 3'd6;
    localparam color_t color_river_2   = 3'd3;
    localparam color_t color_river_3   = 3'd5;
    localparam color_t color_frog      = 3'd7;

endpackage

`default_nettype wire

/* hdl/frog_ctrl_pkg.sv */
`default_nettype none

package frog_ctrl_pkg;

    // Screen and layer sequencer states
    // Each draw state is entered from a wait state on go, or chained on plot_done
    typedef enum logic [3:0] {
        wait_start,
        draw_start,
        wait_game_over,
        draw_game_over,
        wait_game_bg,
        draw_game_bg,
        wait_river,
        draw_river_1,
        draw_river_2,
        draw_river_3,
        wait_frog,
        draw_frog
    } ctrl_state_t;

    // Layer currently being swept
    // layer_none while the sequencer sits in a wait state
    typedef enum logic [2:0] {
        layer_none,
        layer_start,
        layer_game_over,
        layer_bg,
        layer_river_1,
        layer_river_2,
        layer_river_3,
        layer_frog
    } layer_t;

endpackage

`default_nettype wire

/* hdl/go_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module go_pulse (
    input  wire  clk,
    input  wire  reset,
    input  wire  go_key,
    output logic go
);

    // Press cycle local to this conditioner
    typedef enum logic [1:0] {
        go_idle,
        go_hold_1,
        go_hold_2,
        go_release
    } go_state_t;

    go_state_t state;
    go_state_t next_state;

    // One pulse per press
    // A held key parks in go_release until it is let go
    always_comb begin
        case (state)
            go_idle:    next_state = go_key ? go_hold_1 : go_idle;
            go_hold_1:  next_state = go_hold_2;
            go_hold_2:  next_state = go_release;
            go_release: next_state = go_key ? go_release : go_idle;
            default:    next_state = go_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= go_idle;
        end else begin
            state <= next_state;
        end
    end

    // Two cycles wide, second and third cycle after the key rises
    assign go = (state == go_hold_1) || (state == go_hold_2);

endmodule

`default_nettype wire

/* hdl/draw_control.sv */
`timescale 1ns/1ps
`default_nettype none

module draw_control (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   go,
    input  wire                   plot_done,
    output frog_ctrl_pkg::layer_t layer
);

    import frog_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // Transition table
    // Wait states leave on go, draw states leave on the last pixel
    always_comb begin
        case (state)
            wait_start:
                next_state = go ? draw_start : wait_start;
            draw_start:
                next_state = plot_done ? wait_game_over : draw_start;
            wait_game_over:
                next_state = go ? draw_game_over : wait_game_over;
            draw_game_over:
                next_state = plot_done ? wait_game_bg : draw_game_over;
            wait_game_bg:
                next_state = go ? draw_game_bg : wait_game_bg;
            draw_game_bg:
                next_state = plot_done ? wait_river : draw_game_bg;
            wait_river:
                next_state = go ? draw_river_1 : wait_river;
            // River rows chain back to back
            draw_river_1:
                next_state = plot_done ? draw_river_2 : draw_river_1;
            draw_river_2:
                next_state = plot_done ? draw_river_3 : draw_river_2;
            draw_river_3:
                next_state = plot_done ? wait_frog : draw_river_3;
            wait_frog:
                next_state = go ? draw_frog : wait_frog;
            // Game loop, back to the background without a press
            draw_frog:
                next_state = plot_done ? draw_game_bg : draw_frog;
            default:
                next_state = wait_start;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wait_start;
        end else begin
            state <= next_state;
        end
    end

    // Layer decode
    always_comb begin
        case (state)
            draw_start:     layer = layer_start;
            draw_game_over: layer = layer_game_over;
            draw_game_bg:   layer = layer_bg;
            draw_river_1:   layer = layer_river_1;
            draw_river_2:   layer = layer_river_2;
            draw_river_3:   layer = layer_river_3;
            draw_frog:      layer = layer_frog;
            // Nothing to plot while waiting
            default:        layer = layer_none;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/sprite_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_sweep #(
    parameter int size_x = 8,
    parameter int size_y = 8
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   en,
    output frog_geom_pkg::coord_t off_x,
    output frog_geom_pkg::coord_t off_y,
    output logic                  done
);

    import frog_geom_pkg::*;

    logic last_x;
    logic last_y;

    // End of a row and end of the sprite
    assign last_x = (off_x == coord_t'(size_x - 1));
    assign last_y = (off_y == coord_t'(size_y - 1));

    // High during the final offset only
    assign done = en && last_x && last_y;

    // Row-major walk, x is the inner loop
    // Wraps to zero after the last offset so the next layer starts clean
    always_ff @(posedge clk) begin
        if (reset) begin
            off_x <= '0;
            off_y <= '0;
        end else if (en) begin
            if (last_x) begin
                off_x <= '0;
                off_y <= last_y ? '0 : off_y + 9'd1;
            end else begin
                off_x <= off_x + 9'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/object_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module object_tracker (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   frog_ctrl_pkg::layer_t layer,
    input  wire                   plot_done,
    input  wire                   left,
    input  wire                   right,
    input  wire                   up,
    input  wire                   down,
    output frog_geom_pkg::coord_t frog_x,
    output frog_geom_pkg::coord_t frog_y,
    output frog_geom_pkg::coord_t river_1_x,
    output frog_geom_pkg::coord_t river_2_x,
    output frog_geom_pkg::coord_t river_3_x
);

    import frog_geom_pkg::*;
    import frog_ctrl_pkg::*;

    // Candidate frog corner, one bit wider
    // A step below zero lands at 1023 and fails the upper bound as well
    logic [9:0] cand_x;
    logic [9:0] cand_y;

    assign cand_x = {1'b0, frog_x} + {9'd0, right} - {9'd0, left};
    assign cand_y = {1'b0, frog_y} + {9'd0, down} - {9'd0, up};

    // Each object moves once, on the last pixel of its own sweep
    always_ff @(posedge clk) begin
        if (reset) begin
            frog_x    <= '0;
            frog_y    <= '0;
            river_1_x <= frog_geom_pkg::river_1_x;
            river_2_x <= frog_geom_pkg::river_2_x;
            river_3_x <= frog_geom_pkg::river_3_x;
        end else if (plot_done) begin
            case (layer)
                // Rows one and three drift right, row two left
                layer_river_1: river_1_x <= river_1_x + 9'd1;
                layer_river_2: river_2_x <= river_2_x - 9'd1;
                layer_river_3: river_3_x <= river_3_x + 9'd1;
                layer_frog: begin
                    // Axis holds still when the step would leave the screen
                    if (cand_x <= {1'b0, frog_max_x}) begin
                        frog_x <= cand_x[8:0];
                    end
                    if (cand_y <= {1'b0, frog_max_y}) begin
                        frog_y <= cand_y[8:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_emitter.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_emitter (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   frog_ctrl_pkg::layer_t layer,
    input  wire                   frog_geom_pkg::coord_t frog_x,
    input  wire                   frog_geom_pkg::coord_t frog_y,
    input  wire                   frog_geom_pkg::coord_t river_1_x,
    input  wire                   frog_geom_pkg::coord_t river_2_x,
    input  wire                   frog_geom_pkg::coord_t river_3_x,
    output logic                  plot_done,
    output logic                  plot,
    output frog_geom_pkg::coord_t x,
    output frog_geom_pkg::coord_t y,
    output frog_geom_pkg::color_t color
);

    import frog_geom_pkg::*;
    import frog_ctrl_pkg::*;

    logic   screen_en;
    logic   river_en;
    logic   frog_en;
    logic   screen_done;
    logic   river_done;
    logic   frog_done;
    coord_t screen_off_x;
    coord_t screen_off_y;
    coord_t river_off_x;
    coord_t river_off_y;
    coord_t frog_off_x;
    coord_t frog_off_y;
    coord_t pix_x;
    coord_t pix_y;
    color_t pix_color;

    // One sweep per sprite size
    sprite_sweep #(.size_x(scrn_w), .size_y(scrn_h)) screen_sweep (
        .clk(clk), .reset(reset), .en(screen_en),
        .off_x(screen_off_x), .off_y(screen_off_y), .done(screen_done)
    );

    sprite_sweep #(.size_x(river_w), .size_y(river_h)) river_sweep (
        .clk(clk), .reset(reset), .en(river_en),
        .off_x(river_off_x), .off_y(river_off_y), .done(river_done)
    );

    sprite_sweep #(.size_x(frog_w), .size_y(frog_h)) frog_sweep (
        .clk(clk), .reset(reset), .en(frog_en),
        .off_x(frog_off_x), .off_y(frog_off_y), .done(frog_done)
    );

    // Only the active sweep can finish
    assign plot_done = screen_done | river_done | frog_done;

    // Sweep select and pixel position
    // Object corner plus the sweep offset, wrapping at 512
    always_comb begin
        screen_en = 1'b0;
        river_en  = 1'b0;
        frog_en   = 1'b0;
        pix_x     = '0;
        pix_y     = '0;
        case (layer)
            layer_start, layer_game_over, layer_bg: begin
                screen_en = 1'b1;
                pix_x     = screen_off_x;
                pix_y     = screen_off_y;
            end
            layer_river_1: begin
                river_en = 1'b1;
                pix_x    = river_1_x + river_off_x;
                pix_y    = river_1_y + river_off_y;
            end
            layer_river_2: begin
                river_en = 1'b1;
                pix_x    = river_2_x + river_off_x;
                pix_y    = river_2_y + river_off_y;
            end
            layer_river_3: begin
                river_en = 1'b1;
                pix_x    = river_3_x + river_off_x;
                pix_y    = river_3_y + river_off_y;
            end
            layer_frog: begin
                frog_en = 1'b1;
                pix_x   = frog_x + frog_off_x;
                pix_y   = frog_y + frog_off_y;
            end
            default: begin
            end
        endcase
    end

    // Palette lookup
    always_comb begin
        case (layer)
            layer_start:     pix_color = color_start;
            layer_game_over: pix_color = color_game_over;
            layer_bg:        pix_color = color_bg;
            layer_river_1:   pix_color = color_river_1;
            layer_river_2:   pix_color = color_river_2;
            layer_river_3:   pix_color = color_river_3;
            layer_frog:      pix_color = color_frog;
            default:         pix_color = '0;
        endcase
    end

    // Plot strobe, one cycle behind its offset
    always_ff @(posedge clk) begin
        if (reset) begin
            plot <= 1'b0;
        end else begin
            plot <= (layer != layer_none);
        end
    end

    // Pixel payload, qualified by plot
    always_ff @(posedge clk) begin
        x     <= pix_x;
        y     <= pix_y;
        color <= pix_color;
    end

endmodule

`default_nettype wire

/* hdl/frogger_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frogger_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   go_key,
    input  wire                   left,
    input  wire                   right,
    input  wire                   up,
    input  wire                   down,
    output logic                  plot,
    output frog_geom_pkg::coord_t x,
    output frog_geom_pkg::coord_t y,
    output frog_geom_pkg::color_t color
);

    import frog_geom_pkg::*;
    import frog_ctrl_pkg::*;

    logic   go;
    logic   plot_done;
    layer_t layer;
    coord_t frog_x;
    coord_t frog_y;
    coord_t river_1_x;
    coord_t river_2_x;
    coord_t river_3_x;

    // Key conditioning
    go_pulse go_pulse0 (
        .clk(clk), .reset(reset), .go_key(go_key), .go(go)
    );

    // Screen and layer sequencer
    draw_control draw_control0 (
        .clk(clk), .reset(reset), .go(go), .plot_done(plot_done), .layer(layer)
    );

    // Object positions, updated after each sweep
    object_tracker object_tracker0 (
        .clk(clk), .reset(reset), .layer(layer), .plot_done(plot_done),
        .left(left), .right(right), .up(up), .down(down),
        .frog_x(frog_x), .frog_y(frog_y),
        .river_1_x(river_1_x), .river_2_x(river_2_x), .river_3_x(river_3_x)
    );

    // One pixel per clock out of the active layer
    pixel_emitter pixel_emitter0 (
        .clk(clk), .reset(reset), .layer(layer),
        .frog_x(frog_x), .frog_y(frog_y),
        .river_1_x(river_1_x), .river_2_x(river_2_x), .river_3_x(river_3_x),
        .plot_done(plot_done), .plot(plot), .x(x), .y(y), .color(color)
    );

endmodule

`default_nettype wire

/* verif/frogger_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frogger_tb;

    import frog_geom_pkg::*;

    // DUT ports
    logic   clk;
    logic   reset;
    logic   go_key;
    logic   left;
    logic   right;
    logic   up;
    logic   down;
    logic   plot;
    coord_t x;
    coord_t y;
    color_t color;

    // Reference model state
    // Step index follows the screen sequence, 0 is the start wait
    int     m_step;
    int     m_ox;
    int     m_oy;
    int     m_go_age;
    int     m_r1;
    int     m_r2;
    int     m_r3;
    int     m_fx;
    int     m_fy;
    logic   exp_plot;
    coord_t exp_x;
    coord_t exp_y;
    color_t exp_color;

    string  test_name;
    int     errors;

    frogger_top dut0 (
        .clk(clk), .reset(reset), .go_key(go_key),
        .left(left), .right(right), .up(up), .down(down),
        .plot(plot), .x(x), .y(y), .color(color)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic report_mismatch(input string check, input int expected, input int actual);
        errors++;
        $display("FAILED %s %s: expected %0d, actual %0d", test_name, check, expected, actual);
        $display("Errors found");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timed out in %s while waiting for %s", test_name, what);
        $display("Errors found");
        $fatal(1, "Stopped on a timeout");
    endtask

    // Predicted output for every clock
    // Layers sweep row-major, objects move after their last pixel
    always @(posedge clk) begin : ref_model
        int         w;
        int         h;
        int         org_x;
        int         org_y;
        int         nx;
        int         ny;
        color_t     col;
        logic       drawing;
        if (reset) begin
            m_step   <= 0;
            m_ox     <= 0;
            m_oy     <= 0;
            m_go_age <= 0;
            m_r1     <= int'(river_1_x);
            m_r2     <= int'(river_2_x);
            m_r3     <= int'(river_3_x);
            m_fx     <= 0;
            m_fy     <= 0;
            exp_plot <= 1'b0;
        end else begin
            // Full screen by default
            drawing = 1'b1;
            w       = int'(scrn_w);
            h       = int'(scrn_h);
            org_x   = 0;
            org_y   = 0;
            col     = color_bg;
            case (m_step)
                1: col = color_start;
                3: col = color_game_over;
                5: col = color_bg;
                default: drawing = 1'b0;
            endcase
            // River rows and frog use their own sprite size
            if (m_step >= 7 && m_step <= 9) begin
                w     = int'(river_w);
                h     = int'(river_h);
                drawing = 1'b1;
                org_x = (m_step == 7) ? m_r1 : (m_step == 8) ? m_r2 : m_r3;
                org_y = (m_step == 7) ? int'(river_1_y) :
                        (m_step == 8) ? int'(river_2_y) : int'(river_3_y);
                col   = (m_step == 7) ? color_river_1 :
                        (m_step == 8) ? color_river_2 : color_river_3;
            end else if (m_step == 11) begin
                w       = int'(frog_w);
                h       = int'(frog_h);
                drawing = 1'b1;
                org_x   = m_fx;
                org_y   = m_fy;
                col     = color_frog;
            end
            if (drawing) begin
                exp_plot  <= 1'b1;
                exp_x     <= coord_t'(org_x + m_ox);
                exp_y     <= coord_t'(org_y + m_oy);
                exp_color <= col;
                if (m_ox == w - 1) begin
                    m_ox <= 0;
                    m_oy <= (m_oy == h - 1) ? 0 : m_oy + 1;
                end else begin
                    m_ox <= m_ox + 1;
                end
                // Last pixel of the layer
                if (m_ox == w - 1 && m_oy == h - 1) begin
                    m_step <= (m_step == 11) ? 5 : m_step + 1;
                    if (m_step == 7) m_r1 <= (m_r1 + 1) % 512;
                    if (m_step == 8) m_r2 <= (m_r2 + 511) % 512;
                    if (m_step == 9) m_r3 <= (m_r3 + 1) % 512;
                    if (m_step == 11) begin
                        nx = m_fx + int'(right) - int'(left);
                        ny = m_fy + int'(down) - int'(up);
                        // Each axis is clamped on its own
                        if (nx >= 0 && nx <= int'(frog_max_x)) m_fx <= nx;
                        if (ny >= 0 && ny <= int'(frog_max_y)) m_fy <= ny;
                    end
                end
            end else begin
                exp_plot <= 1'b0;
                // Go is high in the second and third cycle after the press
                if (m_go_age == 1 || m_go_age == 2) m_step <= m_step + 1;
            end
            // Key must drop before the next pulse
            if (m_go_age == 0) m_go_age <= go_key ? 1 : 0;
            else if (m_go_age < 3) m_go_age <= m_go_age + 1;
            else m_go_age <= go_key ? 3 : 0;
        end
    end

    // Pixel stream checks
    assert property (@(posedge clk) disable iff (reset) plot == exp_plot)
        else report_mismatch("plot", int'($sampled(exp_plot)), int'($sampled(plot)));
    assert property (@(posedge clk) disable iff (reset) !exp_plot || x == exp_x)
        else report_mismatch("x", int'($sampled(exp_x)), int'($sampled(x)));
    assert property (@(posedge clk) disable iff (reset) !exp_plot || y == exp_y)
        else report_mismatch("y", int'($sampled(exp_y)), int'($sampled(y)));
    assert property (@(posedge clk) disable iff (reset) !exp_plot || color == exp_color)
        else report_mismatch("color", int'($sampled(exp_color)), int'($sampled(color)));

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Press go for hold cycles and count one burst of plotted pixels
    // A hold longer than the burst keeps the key down into the next wait
    task automatic run_burst(input string name, input int hold, input int expected);
        int   count;
        int   cycles;
        int   limit;
        logic seen;
        logic finished;
        test_name = name;
        count     = 0;
        cycles    = 0;
        seen      = 1'b0;
        finished  = 1'b0;
        limit     = expected + hold + 1000;
        go_key <= 1'b1;
        while ((!finished || cycles < hold) && cycles < limit) begin
            @(posedge clk);
            cycles++;
            if (cycles == hold) go_key <= 1'b0;
            if (plot) begin
                count++;
                seen = 1'b1;
            end else if (seen) begin
                finished = 1'b1;
            end
        end
        if (!finished) report_timeout("the end of the plot burst");
        else if (count != expected) report_mismatch("pixel count", expected, count);
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        int          pass;
        errors    = 0;
        test_name = "reset";
        rnd       = 32'h5ef908e7;
        reset  <= 1'b1;
        go_key <= 1'b0;
        left   <= 1'b0;
        right  <= 1'b0;
        up     <= 1'b0;
        down   <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        // Nothing plots before the first press
        test_name = "idle after reset";
        idle_cycles(100);
        // Key still down 200 cycles into the game over wait
        // One screen only
        run_burst("start screen", 76800 + 200, 76800);
        test_name = "idle after start";
        idle_cycles(300);
        run_burst("game over screen", 3, 76800);
        run_burst("background", 3, 76800);
        for (pass = 0; pass < 16; pass++) begin
            run_burst("river pass", 3, 3 * 2880);
            // Directions change only in the frog wait
            if (pass < 3) begin
                left  <= 1'b1;
                up    <= 1'b1;
                right <= 1'b0;
                down  <= 1'b0;
            end else begin
                rnd = xorshift32(rnd);
                left  <= rnd[0];
                right <= rnd[1];
                up    <= rnd[2];
                down  <= rnd[3];
            end
            // Frog chains straight into the background
            run_burst("frog pass", 3, 768 + 76800);
        end
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/frog_geom_pkg.sv
hdl/frog_ctrl_pkg.sv
hdl/go_pulse.sv
hdl/draw_control.sv
hdl/sprite_sweep.sv
hdl/object_tracker.sv
hdl/pixel_emitter.sv
hdl/frogger_top.sv
verif/frogger_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := frogger_tb
FILELIST := sources.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), fail unless the pass message appears"
	@echo "  clean  remove the obj_dir build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
